/* hdl/bft_params.svh */
// BFT network geometry
`ifndef BFT_PARAMS_SVH
`define BFT_PARAMS_SVH

// leaves at the bottom of the tree
`define BFT_NUM_LEAVES 4

// destination field, one bit per tree level
`define BFT_ADDR_W 2

// data carried by each packet
`define BFT_PAYLOAD_W 8

// valid + dest + payload
`define BFT_PKT_W (1 + `BFT_ADDR_W + `BFT_PAYLOAD_W)

`endif

/* hdl/bft_pkg.sv */
// BFT shared types
`include "bft_params.svh"

package bft_pkg;

	// one link slot, valid bit on top
	typedef struct packed {
		logic valid;
		logic [`BFT_ADDR_W-1:0] dest;
		logic [`BFT_PAYLOAD_W-1:0] payload;
	} packet_t;

	// wanted direction of an input packet, and also the select code of an
	// output port, which then names the input that feeds it
	typedef enum logic [1:0] {
		DIR_VOID  = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP    = 2'b11
	} dir_t;

	// injection handshake at a leaf
	typedef enum logic [1:0] {
		INJ_IDLE      = 2'b00,
		INJ_WAIT_SLOT = 2'b01,
		INJ_ACK       = 2'b10,
		INJ_WAIT_DROP = 2'b11
	} inj_state_t;

endpackage

/* hdl/tree_arbiter.sv */
// Tree switch arbiter
`timescale 1ns/10ps

module tree_arbiter #(
	parameter int LEVEL = 1
) (
	input  bft_pkg::dir_t d_l_i,
	input  bft_pkg::dir_t d_r_i,
	input  bft_pkg::dir_t d_u_i,
	output bft_pkg::dir_t sel_l_o,
	output bft_pkg::dir_t sel_r_o,
	output bft_pkg::dir_t sel_u_o
);

	if (LEVEL == 0) begin : g_root
		// root has only two live ports, no up link
		always_comb begin
			sel_l_o = bft_pkg::DIR_VOID;
			sel_r_o = bft_pkg::DIR_VOID;
			sel_u_o = bft_pkg::DIR_VOID;
			// turnback first
			if (d_l_i == bft_pkg::DIR_LEFT)
				sel_l_o = bft_pkg::DIR_LEFT;
			if (d_r_i == bft_pkg::DIR_RIGHT)
				sel_r_o = bft_pkg::DIR_RIGHT;
			// crossing packets, deflect back where they came from on conflict
			if (d_r_i == bft_pkg::DIR_LEFT) begin
				if (sel_l_o == bft_pkg::DIR_VOID)
					sel_l_o = bft_pkg::DIR_RIGHT;
				else
					sel_r_o = bft_pkg::DIR_RIGHT;
			end
			if (d_l_i == bft_pkg::DIR_RIGHT) begin
				if (sel_r_o == bft_pkg::DIR_VOID)
					sel_r_o = bft_pkg::DIR_LEFT;
				else
					sel_l_o = bft_pkg::DIR_LEFT;
			end
		end
	end else begin : g_tree
		// an output still at VOID is free for the next claimant
		always_comb begin
			sel_l_o = bft_pkg::DIR_VOID;
			sel_r_o = bft_pkg::DIR_VOID;
			sel_u_o = bft_pkg::DIR_VOID;
			// turnback
			if (d_l_i == bft_pkg::DIR_LEFT)
				sel_l_o = bft_pkg::DIR_LEFT;
			if (d_r_i == bft_pkg::DIR_RIGHT)
				sel_r_o = bft_pkg::DIR_RIGHT;
			if (d_u_i == bft_pkg::DIR_UP)
				sel_u_o = bft_pkg::DIR_UP;
			// downlink, bounced back up when the child link is taken
			if (d_u_i == bft_pkg::DIR_LEFT) begin
				if (sel_l_o == bft_pkg::DIR_VOID)
					sel_l_o = bft_pkg::DIR_UP;
				else
					sel_u_o = bft_pkg::DIR_UP;
			end else if (d_u_i == bft_pkg::DIR_RIGHT) begin
				if (sel_r_o == bft_pkg::DIR_VOID)
					sel_r_o = bft_pkg::DIR_UP;
				else
					sel_u_o = bft_pkg::DIR_UP;
			end
			// side links
			if (d_l_i == bft_pkg::DIR_RIGHT) begin
				if (sel_r_o == bft_pkg::DIR_VOID)
					sel_r_o = bft_pkg::DIR_LEFT;
				else if (sel_l_o == bft_pkg::DIR_VOID)
					sel_l_o = bft_pkg::DIR_LEFT;
				else
					sel_u_o = bft_pkg::DIR_LEFT;
			end
			if (d_r_i == bft_pkg::DIR_LEFT) begin
				if (sel_l_o == bft_pkg::DIR_VOID)
					sel_l_o = bft_pkg::DIR_RIGHT;
				else if (sel_r_o == bft_pkg::DIR_VOID)
					sel_r_o = bft_pkg::DIR_RIGHT;
				else
					sel_u_o = bft_pkg::DIR_RIGHT;
			end
			// uplinks last, prefer bouncing back toward the sender
			if (d_l_i == bft_pkg::DIR_UP) begin
				if (sel_u_o == bft_pkg::DIR_VOID)
					sel_u_o = bft_pkg::DIR_LEFT;
				else if (sel_l_o == bft_pkg::DIR_VOID)
					sel_l_o = bft_pkg::DIR_LEFT;
				else
					sel_r_o = bft_pkg::DIR_LEFT;
			end
			if (d_r_i == bft_pkg::DIR_UP) begin
				if (sel_u_o == bft_pkg::DIR_VOID)
					sel_u_o = bft_pkg::DIR_RIGHT;
				else if (sel_r_o == bft_pkg::DIR_VOID)
					sel_r_o = bft_pkg::DIR_RIGHT;
				else
					sel_l_o = bft_pkg::DIR_RIGHT;
			end
		end
	end

endmodule

/* hdl/tree_switch.sv */
// Registered tree switch
`timescale 1ns/10ps
`include "bft_params.svh"

module tree_switch #(
	parameter int LEVEL     = 1,
	parameter int NODE_ADDR = 0
) (
	input  logic             clk,
	input  logic             reset,
	input  bft_pkg::packet_t l_i,
	input  bft_pkg::packet_t r_i,
	input  bft_pkg::packet_t u_i,
	output bft_pkg::packet_t l_o,
	output bft_pkg::packet_t r_o,
	output bft_pkg::packet_t u_o
);

	bft_pkg::packet_t u_in;
	bft_pkg::dir_t    d_l, d_r, d_u;
	bft_pkg::dir_t    sel_l, sel_r, sel_u;
	logic [1:0]       n_in, n_out;

	// direction rule, top dest bit picks the subtree
	function automatic bft_pkg::dir_t route(input bft_pkg::packet_t p);
		if (!p.valid)
			return bft_pkg::DIR_VOID;
		if (LEVEL == 0)
			return p.dest[`BFT_ADDR_W-1] ? bft_pkg::DIR_RIGHT : bft_pkg::DIR_LEFT;
		if (p.dest[`BFT_ADDR_W-1] == NODE_ADDR[0])
			return p.dest[0] ? bft_pkg::DIR_RIGHT : bft_pkg::DIR_LEFT;
		return bft_pkg::DIR_UP;
	endfunction

	function automatic bft_pkg::packet_t pick(input bft_pkg::dir_t sel);
		case (sel)
			bft_pkg::DIR_LEFT:  return l_i;
			bft_pkg::DIR_RIGHT: return r_i;
			bft_pkg::DIR_UP:    return u_in;
			default:            return '0;
		endcase
	endfunction

	function automatic logic [1:0] n_valid(input bft_pkg::packet_t a,
		input bft_pkg::packet_t b, input bft_pkg::packet_t c);
		return 2'(a.valid) + 2'(b.valid) + 2'(c.valid);
	endfunction

	function automatic logic granted(input bft_pkg::dir_t src);
		return (sel_l == src) || (sel_r == src) || (sel_u == src);
	endfunction

	// root has no parent link
	if (LEVEL == 0) begin : g_root
		assign u_in = '0;
	end else begin : g_branch
		assign u_in = u_i;
	end

	assign d_l = route(l_i);
	assign d_r = route(r_i);
	assign d_u = route(u_in);

	tree_arbiter #(
		.LEVEL(LEVEL)
	) u_arb (
		.d_l_i  (d_l),
		.d_r_i  (d_r),
		.d_u_i  (d_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			l_o <= '0;
			r_o <= '0;
			u_o <= '0;
		end else begin
			l_o <= pick(sel_l);
			r_o <= pick(sel_r);
			u_o <= pick(sel_u);
		end
	end

	assign n_in  = n_valid(l_i, r_i, u_in);
	assign n_out = n_valid(l_o, r_o, u_o);

	// arbiter never hands one input to two outputs
	a_unique_sel: assert property (@(posedge clk) disable iff (reset)
		(sel_l == bft_pkg::DIR_VOID || (sel_l != sel_r && sel_l != sel_u)) &&
		(sel_r == bft_pkg::DIR_VOID || sel_r != sel_u));

	// deflection must place every valid input somewhere
	a_no_drop: assert property (@(posedge clk) disable iff (reset)
		(!l_i.valid || granted(bft_pkg::DIR_LEFT)) &&
		(!r_i.valid || granted(bft_pkg::DIR_RIGHT)) &&
		(!u_in.valid || granted(bft_pkg::DIR_UP)));

	// bufferless hop, packets in equal packets out one cycle on
	a_conserve: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> n_out == $past(n_in));

endmodule

/* hdl/inject_fsm.sv */
// Leaf injection handshake FSM
`timescale 1ns/10ps

module inject_fsm (
	input  logic clk,
	input  logic reset,
	input  logic inj_req_i,
	input  logic slot_free_i,
	output logic load_o,
	output logic inj_ack_o
);

	bft_pkg::inj_state_t state, state_next;

	always_ff @(posedge clk) begin
		if (reset)
			state <= bft_pkg::INJ_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		load_o     = 1'b0;
		case (state)
			bft_pkg::INJ_IDLE, bft_pkg::INJ_WAIT_SLOT: begin
				if (inj_req_i && slot_free_i) begin
					load_o     = 1'b1;
					state_next = bft_pkg::INJ_ACK;
				end else if (inj_req_i) begin
					state_next = bft_pkg::INJ_WAIT_SLOT;
				end else begin
					state_next = bft_pkg::INJ_IDLE;
				end
			end
			// packet is on the uplink now
			bft_pkg::INJ_ACK: begin
				if (inj_req_i)
					state_next = bft_pkg::INJ_WAIT_DROP;
				else
					state_next = bft_pkg::INJ_IDLE;
			end
			bft_pkg::INJ_WAIT_DROP: begin
				if (!inj_req_i)
					state_next = bft_pkg::INJ_IDLE;
			end
			default: state_next = bft_pkg::INJ_IDLE;
		endcase
	end

	// ack high from the cycle after the load until req is seen low
	assign inj_ack_o = (state == bft_pkg::INJ_ACK) || (state == bft_pkg::INJ_WAIT_DROP);

	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(inj_ack_o) |-> $past(inj_req_i));

endmodule

/* hdl/leaf_port.sv */
// Leaf port with eject and inject
`timescale 1ns/10ps
`include "bft_params.svh"

module leaf_port #(
	parameter logic [`BFT_ADDR_W-1:0] NODE_ADDR = '0
) (
	input  logic             clk,
	input  logic             reset,
	input  bft_pkg::packet_t up_i,
	output bft_pkg::packet_t up_o,
	input  bft_pkg::packet_t inj_pkt_i,
	input  logic             inj_req_i,
	output logic             inj_ack_o,
	output bft_pkg::packet_t eject_pkt_o
);

	logic own, slot_free, load;

	assign own = up_i.valid && (up_i.dest == NODE_ADDR);
	// a foreign packet must go straight back up, so it owns the slot
	assign slot_free = !(up_i.valid && !own);

	inject_fsm u_fsm (
		.clk        (clk),
		.reset      (reset),
		.inj_req_i  (inj_req_i),
		.slot_free_i(slot_free),
		.load_o     (load),
		.inj_ack_o  (inj_ack_o)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			up_o        <= '0;
			eject_pkt_o <= '0;
		end else begin
			eject_pkt_o <= own ? up_i : '0;
			if (!slot_free) begin
				up_o <= up_i;
			end else if (load) begin
				// valid forced, the PE only supplies dest and payload
				up_o.valid   <= 1'b1;
				up_o.dest    <= inj_pkt_i.dest;
				up_o.payload <= inj_pkt_i.payload;
			end else begin
				up_o <= '0;
			end
		end
	end

endmodule

/* hdl/bft_top.sv */
// Four-leaf BFT network
`timescale 1ns/10ps
`include "bft_params.svh"

module bft_top (
	input  logic                                     clk,
	input  logic                                     reset,
	input  bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0]   inj_pkt_i,
	input  logic [`BFT_NUM_LEAVES-1:0]               inj_req_i,
	output logic [`BFT_NUM_LEAVES-1:0]               inj_ack_o,
	output bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0]   eject_pkt_o
);

	// leaf side links, up toward and down from the level-1 switches
	bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0]   leaf_up, leaf_down;
	// level-1 to root links
	bft_pkg::packet_t [`BFT_NUM_LEAVES/2-1:0] mid_up, mid_down;

	tree_switch #(
		.LEVEL    (0),
		.NODE_ADDR(0)
	) u_root (
		.clk  (clk),
		.reset(reset),
		.l_i  (mid_up[0]),
		.r_i  (mid_up[1]),
		.u_i  ('0),
		.l_o  (mid_down[0]),
		.r_o  (mid_down[1]),
		.u_o  ()
	);

	for (genvar k = 0; k < `BFT_NUM_LEAVES/2; k++) begin : g_mid
		tree_switch #(
			.LEVEL    (1),
			.NODE_ADDR(k)
		) u_sw (
			.clk  (clk),
			.reset(reset),
			.l_i  (leaf_up[2*k]),
			.r_i  (leaf_up[2*k+1]),
			.u_i  (mid_down[k]),
			.l_o  (leaf_down[2*k]),
			.r_o  (leaf_down[2*k+1]),
			.u_o  (mid_up[k])
		);
	end

	for (genvar i = 0; i < `BFT_NUM_LEAVES; i++) begin : g_leaf
		leaf_port #(
			.NODE_ADDR(i)
		) u_leaf (
			.clk        (clk),
			.reset      (reset),
			.up_i       (leaf_down[i]),
			.up_o       (leaf_up[i]),
			.inj_pkt_i  (inj_pkt_i[i]),
			.inj_req_i  (inj_req_i[i]),
			.inj_ack_o  (inj_ack_o[i]),
			.eject_pkt_o(eject_pkt_o[i])
		);
	end

endmodule

/* bench/tb_checker.sv */
// BFT scoreboard and handshake monitor
`timescale 1ns/10ps
`include "bft_params.svh"

module tb_checker (
	input  logic                                   clk,
	input  logic                                   reset,
	input  bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0] inj_pkt_i,
	input  logic [`BFT_NUM_LEAVES-1:0]             inj_req_i,
	input  logic [`BFT_NUM_LEAVES-1:0]             inj_ack_i,
	input  bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0] eject_pkt_i,
	output int                                     err_cnt_o,
	output int                                     accepted_o,
	output int                                     delivered_o,
	output int                                     outstanding_o
);

	// expected packets, dest field names the leaf that must eject it
	bft_pkg::packet_t exp_q[$];
	logic [`BFT_NUM_LEAVES-1:0] req_q, ack_q;
	logic started;
	int errors, accepted, delivered;

	assign err_cnt_o     = errors;
	assign accepted_o    = accepted;
	assign delivered_o   = delivered;
	assign outstanding_o = accepted - delivered;

	function automatic int find_expected(input bft_pkg::packet_t p, input int leaf);
		for (int k = 0; k < exp_q.size(); k++) begin
			if (int'(exp_q[k].dest) == leaf && exp_q[k].payload == p.payload)
				return k;
		end
		return -1;
	endfunction

	always @(posedge clk) begin : scan
		int idx;
		if (reset) begin
			exp_q.delete();
			req_q = '0;
			ack_q = '0;
			started = 1'b0;
			errors = 0;
			accepted = 0;
			delivered = 0;
		end else begin
			// nothing may move before the first request
			if (!started && inj_ack_i != 0) begin
				$display("[FAIL] inj_ack_o got %h expected 0", inj_ack_i);
				errors++;
			end
			for (int i = 0; i < `BFT_NUM_LEAVES; i++) begin
				if (!started && eject_pkt_i[i].valid) begin
					$display("[FAIL] eject_pkt_o[%0d] got %h expected 000", i, eject_pkt_i[i]);
					errors++;
				end
				// ack rising marks an accepted injection
				if (inj_ack_i[i] && !ack_q[i]) begin
					if (!req_q[i]) begin
						$display("[FAIL] inj_ack_o[%0d] rose with inj_req_i %h", i, req_q[i]);
						errors++;
					end
					exp_q.push_back({1'b1, inj_pkt_i[i].dest, inj_pkt_i[i].payload});
					accepted++;
				end
				if (ack_q[i] && !inj_ack_i[i] && req_q[i]) begin
					$display("[FAIL] inj_ack_o[%0d] fell with inj_req_i %h", i, req_q[i]);
					errors++;
				end
			end
			for (int i = 0; i < `BFT_NUM_LEAVES; i++) begin
				if (eject_pkt_i[i].valid) begin
					if (int'(eject_pkt_i[i].dest) != i) begin
						$display("[FAIL] eject_pkt_o[%0d].dest got %h expected %h",
							i, eject_pkt_i[i].dest, i[1:0]);
						errors++;
					end
					idx = find_expected(eject_pkt_i[i], i);
					if (idx < 0) begin
						$display("[FAIL] eject_pkt_o[%0d] got %h, no such packet expected",
							i, eject_pkt_i[i]);
						errors++;
					end else begin
						exp_q.delete(idx);
						delivered++;
					end
				end
			end
			if (inj_req_i != 0)
				started = 1'b1;
			req_q = inj_req_i;
			ack_q = inj_ack_i;
		end
	end

endmodule

/* bench/tb_top.sv */
// BFT network testbench
`timescale 1ns/10ps
`include "bft_params.svh"

module tb_top;

	localparam int STIM_WORDS    = 100;
	localparam int ACK_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 500;
	localparam int RAND_ROUNDS   = 40;

	logic clk;
	logic reset;
	bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0] inj_pkt;
	logic [`BFT_NUM_LEAVES-1:0]             inj_req;
	logic [`BFT_NUM_LEAVES-1:0]             inj_ack;
	bft_pkg::packet_t [`BFT_NUM_LEAVES-1:0] eject_pkt;

	int chk_errors, accepted, delivered, outstanding;
	int tb_errors, sent;
	logic aborted;
	logic [15:0] lfsr;
	// four words per line: group, source, destination, payload
	logic [7:0] stim_mem [0:STIM_WORDS-1];

	bft_top UUT (
		.clk        (clk),
		.reset      (reset),
		.inj_pkt_i  (inj_pkt),
		.inj_req_i  (inj_req),
		.inj_ack_o  (inj_ack),
		.eject_pkt_o(eject_pkt)
	);

	tb_checker u_checker (
		.clk          (clk),
		.reset        (reset),
		.inj_pkt_i    (inj_pkt),
		.inj_req_i    (inj_req),
		.inj_ack_i    (inj_ack),
		.eject_pkt_i  (eject_pkt),
		.err_cnt_o    (chk_errors),
		.accepted_o   (accepted),
		.delivered_o  (delivered),
		.outstanding_o(outstanding)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// all leaves in mask run req/ack side by side
	// leaf i keeps req up for i more cycles once it sees ack
	task automatic handshake(input logic [`BFT_NUM_LEAVES-1:0] mask);
		logic [`BFT_NUM_LEAVES-1:0] pending;
		int held [`BFT_NUM_LEAVES];
		int cycles;
		pending = mask;
		cycles = 0;
		for (int i = 0; i < `BFT_NUM_LEAVES; i++)
			held[i] = 0;
		inj_req = mask;
		while (pending != 0 && cycles < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
			for (int i = 0; i < `BFT_NUM_LEAVES; i++) begin
				if (inj_req[i] && inj_ack[i]) begin
					if (held[i] >= i)
						inj_req[i] = 1'b0;
					else
						held[i]++;
				end else if (!inj_req[i] && !inj_ack[i]) begin
					pending[i] = 1'b0;
				end
			end
		end
		if (pending != 0) begin
			$display("timeout in the req/ack handshake, leaves still pending %b", pending);
			tb_errors++;
			aborted = 1'b1;
		end else begin
			sent += $countones(mask);
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (!aborted && outstanding != 0 && cycles < DRAIN_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!aborted && outstanding != 0) begin
			$display("timeout with %0d packets never delivered", outstanding);
			tb_errors++;
			aborted = 1'b1;
		end
	endtask

	// lines sharing a group number are injected together
	task automatic run_directed();
		logic [`BFT_NUM_LEAVES-1:0] mask;
		logic [7:0] grp;
		logic [1:0] src;
		int line;
		line = 0;
		while (!aborted && stim_mem[4*line] != 8'hff) begin
			grp = stim_mem[4*line];
			mask = '0;
			while (stim_mem[4*line] == grp) begin
				src = stim_mem[4*line+1][1:0];
				inj_pkt[src] = {1'b1, stim_mem[4*line+2][1:0], stim_mem[4*line+3]};
				mask[src] = 1'b1;
				line++;
			end
			handshake(mask);
			wait_drain();
		end
	endtask

	task automatic run_random();
		logic [7:0] bits;
		logic [1:0] dest;
		for (int n = 0; n < RAND_ROUNDS && !aborted; n++) begin
			for (int i = 0; i < `BFT_NUM_LEAVES; i++) begin
				take_bits(2, bits);
				dest = bits[1:0];
				take_bits(8, bits);
				inj_pkt[i] = {1'b1, dest, bits};
			end
			handshake('1);
		end
		wait_drain();
	endtask

	initial begin
		tb_errors = 0;
		sent = 0;
		aborted = 1'b0;
		lfsr = 16'd44;
		reset = 1'b1;
		inj_req = '0;
		inj_pkt = '0;
		$readmemh("bench/bft_stim.txt", stim_mem);
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		run_directed();
		run_random();
		if (!aborted && accepted != sent) begin
			$display("checker saw %0d accepted injections, bench completed %0d", accepted, sent);
			tb_errors++;
		end
		$display("errors %0d (checker %0d, bench %0d), sent %0d, accepted %0d, delivered %0d",
			chk_errors + tb_errors, chk_errors, tb_errors, sent, accepted, delivered);
		if (chk_errors + tb_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* bench/bft_stim.txt */
// group source destination payload, all hex
// groups 10 and 11 send from every leaf to one destination, ff ends the list
00 0 0 10
01 0 1 11
02 0 2 12
03 0 3 13
04 1 0 20
05 1 1 21
06 1 2 22
07 1 3 23
08 2 0 30
09 2 1 31
0a 2 2 32
0b 2 3 33
0c 3 0 40
0d 3 1 41
0e 3 2 42
0f 3 3 43
10 0 2 a0
10 1 2 a1
10 2 2 a2
10 3 2 a3
11 0 1 b0
11 1 1 b1
11 2 1 b2
11 3 1 b3
ff ff ff ff

/* project.f */
+incdir+hdl
hdl/bft_pkg.sv
hdl/tree_arbiter.sv
hdl/tree_switch.sv
hdl/inject_fsm.sv
hdl/leaf_port.sv
hdl/bft_top.sv
bench/tb_checker.sv
bench/tb_top.sv

/* Makefile */
# Verilator flow for the BFT network

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
